// ==== build.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_latch.sv
src/inst_decoder.sv
src/reg_rename_file.sv
src/operand_branch_unit.sv
src/dispatch_reg.sv
src/id_top.sv
tb/tb_id_top.sv

// ==== src/dispatch_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_reg (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    in_valid,
  input  wire pipe_pkg::dispatch_pkt_t next_pkt,
  output logic                         dispatch_valid,
  output pipe_pkg::dispatch_pkt_t      dispatch
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dispatch_valid <= 1'b0;
    end else begin
      dispatch_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dispatch <= next_pkt;
    end
  end

  // a reserved instruction leaves with every enable low
  a_reserved_quiet: assert property (
    @(posedge clk) disable iff (!arst_n)
    (in_valid && next_pkt.reserved_inst) |->
      !(next_pkt.reg_write_en || next_pkt.mem_read || next_pkt.mem_write ||
        next_pkt.is_branch)
  ) else $error("reserved instruction dispatched with an enable set");

endmodule

`default_nettype wire

// ==== src/fetch_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_latch (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 fetch_valid,
  input  wire pipe_pkg::fetch_pkt_t fetch,
  output logic                      lat_valid,
  output pipe_pkg::fetch_pkt_t      lat_pkt
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lat_valid <= 1'b0;
    end else begin
      lat_valid <= fetch_valid;
    end
  end

  // payload holds until the next strobe
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      lat_pkt <= fetch;
    end
  end

  // fetch only ever hands over word addresses
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    fetch_valid |-> (fetch.pc[1:0] == 2'b00)
  ) else $error("fetch pc not word aligned: %h", fetch.pc);

endmodule

`default_nettype wire

// ==== src/id_config.svh ====
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// datapath widths
`define DATA_W      32
`define ADDR_W      32

// register file and renaming
`define REG_ADDR_W  5
`define NUM_REGS    32
`define RSID_W      4

// jal writes its return address here
`define LINK_REG    31

// shift amount field of R-type
`define SHAMT_W     5

// byte enables for memory access
`define MEM_SEL_W   4

`endif

// ==== src/id_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module id_top (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 fetch_valid,
  input  wire pipe_pkg::fetch_pkt_t fetch,
  input  wire logic                 wb_valid,
  input  wire pipe_pkg::wb_pkt_t    wb,
  output logic                      dispatch_valid,
  output pipe_pkg::dispatch_pkt_t   dispatch
);

  logic                    lat_valid;
  pipe_pkg::fetch_pkt_t    lat_pkt;
  pipe_pkg::ctrl_t         ctrl;
  pipe_pkg::rd_rsp_t       rsp_1;
  pipe_pkg::rd_rsp_t       rsp_2;
  logic [`RSID_W-1:0]      alloc_tag;
  pipe_pkg::dispatch_pkt_t next_pkt;

  fetch_latch u_fetch_latch (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .lat_valid   (lat_valid),
    .lat_pkt     (lat_pkt)
  );

  inst_decoder u_inst_decoder (
    .lat_pkt (lat_pkt),
    .ctrl    (ctrl)
  );

  reg_rename_file u_reg_rename_file (
    .clk         (clk),
    .arst_n      (arst_n),
    .rd_1        (ctrl.rd_1),
    .rd_2        (ctrl.rd_2),
    .rsp_1       (rsp_1),
    .rsp_2       (rsp_2),
    .alloc_valid (lat_valid & ctrl.reg_write_en),
    .alloc_addr  (ctrl.reg_write_addr),
    .alloc_tag   (alloc_tag),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  operand_branch_unit u_operand_branch_unit (
    .lat_pkt   (lat_pkt),
    .ctrl      (ctrl),
    .rsp_1     (rsp_1),
    .rsp_2     (rsp_2),
    .alloc_tag (alloc_tag),
    .next_pkt  (next_pkt)
  );

  dispatch_reg u_dispatch_reg (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid       (lat_valid),
    .next_pkt       (next_pkt),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch)
  );

endmodule

`default_nettype wire

// ==== src/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module inst_decoder (
  input  wire pipe_pkg::fetch_pkt_t lat_pkt,
  output pipe_pkg::ctrl_t           ctrl
);

  isa_pkg::inst_u inst;
  logic           rsv;

  assign inst = lat_pkt.inst;

  always_comb begin
    ctrl             = '0;
    ctrl.funct       = isa_pkg::FN_ADDU;
    ctrl.branch_kind = isa_pkg::BR_NONE;
    rsv              = 1'b0;

    case (inst.r.opcode)
      isa_pkg::OP_SPECIAL: begin
        case (inst.r.funct)
          isa_pkg::FN_ADD, isa_pkg::FN_ADDU, isa_pkg::FN_SUB, isa_pkg::FN_SUBU,
          isa_pkg::FN_AND, isa_pkg::FN_OR, isa_pkg::FN_XOR, isa_pkg::FN_NOR,
          isa_pkg::FN_SLT: begin
            ctrl.funct          = isa_pkg::funct_e'(inst.r.funct);
            ctrl.rd_1           = '{en: 1'b1, addr: inst.r.rs};
            ctrl.rd_2           = '{en: 1'b1, addr: inst.r.rt};
            ctrl.reg_write_en   = 1'b1;
            ctrl.reg_write_addr = inst.r.rd;
          end
          // shifts take rt and the shamt field only
          isa_pkg::FN_SLL, isa_pkg::FN_SRL: begin
            ctrl.funct          = isa_pkg::funct_e'(inst.r.funct);
            ctrl.shamt          = inst.r.shamt;
            ctrl.rd_2           = '{en: 1'b1, addr: inst.r.rt};
            ctrl.reg_write_en   = 1'b1;
            ctrl.reg_write_addr = inst.r.rd;
          end
          isa_pkg::FN_JR: begin
            ctrl.rd_1        = '{en: 1'b1, addr: inst.r.rs};
            ctrl.branch_kind = isa_pkg::BR_JR;
          end
          default: rsv = 1'b1;
        endcase
      end

      // I-type ALU ops, funct follows the opcode
      isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_ANDI,
      isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI: begin
        ctrl.rd_1           = '{en: 1'b1, addr: inst.i.rs};
        ctrl.use_imm        = 1'b1;
        ctrl.reg_write_en   = 1'b1;
        ctrl.reg_write_addr = inst.i.rt;
        case (inst.i.opcode)
          isa_pkg::OP_ADDI: begin
            ctrl.funct        = isa_pkg::FN_ADD;
            ctrl.sign_ext_imm = 1'b1;
          end
          isa_pkg::OP_ADDIU: begin
            ctrl.funct        = isa_pkg::FN_ADDU;
            ctrl.sign_ext_imm = 1'b1;
          end
          isa_pkg::OP_SLTI: begin
            ctrl.funct        = isa_pkg::FN_SLT;
            ctrl.sign_ext_imm = 1'b1;
          end
          isa_pkg::OP_ANDI: ctrl.funct = isa_pkg::FN_AND;
          isa_pkg::OP_ORI:  ctrl.funct = isa_pkg::FN_OR;
          isa_pkg::OP_XORI: ctrl.funct = isa_pkg::FN_XOR;
          default: begin
            // lui: 0 | (imm << 16), rs is not read
            ctrl.funct = isa_pkg::FN_OR;
            ctrl.lui   = 1'b1;
            ctrl.rd_1  = '0;
          end
        endcase
      end

      isa_pkg::OP_LW, isa_pkg::OP_LB, isa_pkg::OP_LBU: begin
        ctrl.rd_1           = '{en: 1'b1, addr: inst.i.rs};
        ctrl.use_imm        = 1'b1;
        ctrl.sign_ext_imm   = 1'b1;
        ctrl.mem_read       = 1'b1;
        ctrl.mem_sign_ext   = (inst.i.opcode == isa_pkg::OP_LB);
        ctrl.mem_sel        = (inst.i.opcode == isa_pkg::OP_LW) ? 4'b1111 : 4'b0001;
        ctrl.reg_write_en   = 1'b1;
        ctrl.reg_write_addr = inst.i.rt;
      end

      isa_pkg::OP_SW, isa_pkg::OP_SB: begin
        ctrl.rd_1         = '{en: 1'b1, addr: inst.i.rs};
        ctrl.rd_2         = '{en: 1'b1, addr: inst.i.rt};
        ctrl.use_imm      = 1'b1;
        ctrl.sign_ext_imm = 1'b1;
        ctrl.mem_write    = 1'b1;
        ctrl.mem_sel      = (inst.i.opcode == isa_pkg::OP_SW) ? 4'b1111 : 4'b0001;
      end

      isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
        ctrl.rd_1        = '{en: 1'b1, addr: inst.i.rs};
        ctrl.rd_2        = '{en: 1'b1, addr: inst.i.rt};
        ctrl.branch_kind = (inst.i.opcode == isa_pkg::OP_BEQ) ?
                           isa_pkg::BR_BEQ : isa_pkg::BR_BNE;
      end

      isa_pkg::OP_J: ctrl.branch_kind = isa_pkg::BR_J;

      isa_pkg::OP_JAL: begin
        ctrl.branch_kind    = isa_pkg::BR_JAL;
        ctrl.reg_write_en   = 1'b1;
        ctrl.reg_write_addr = `REG_ADDR_W'(`LINK_REG);
      end

      default: rsv = 1'b1;
    endcase

    // writes to r0 are dropped, no tag is spent on them
    if (ctrl.reg_write_addr == '0) begin
      ctrl.reg_write_en = 1'b0;
    end

    if (rsv) begin
      ctrl               = '0;
      ctrl.reserved_inst = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] index;
  } j_fmt_t;

  // one instruction word, three views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } inst_u;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_SB      = 6'h28,
    OP_SW      = 6'h2b
  } opcode_e;

  // also used as the ALU function code
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADD  = 6'h20,
    FN_ADDU = 6'h21,
    FN_SUB  = 6'h22,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_BEQ  = 3'd1,
    BR_BNE  = 3'd2,
    BR_J    = 3'd3,
    BR_JAL  = 3'd4,
    BR_JR   = 3'd5
  } branch_kind_e;

endpackage

`default_nettype wire

// ==== src/operand_branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module operand_branch_unit (
  input  wire pipe_pkg::fetch_pkt_t lat_pkt,
  input  wire pipe_pkg::ctrl_t      ctrl,
  input  wire pipe_pkg::rd_rsp_t    rsp_1,
  input  wire pipe_pkg::rd_rsp_t    rsp_2,
  input  wire logic [`RSID_W-1:0]   alloc_tag,
  output pipe_pkg::dispatch_pkt_t   next_pkt
);

  isa_pkg::inst_u     inst;
  logic [`ADDR_W-1:0] pc_plus4;
  logic [`ADDR_W-1:0] pc_plus8;
  logic [`DATA_W-1:0] imm_ext;
  logic [`ADDR_W-1:0] br_offset;
  logic               both_known;
  logic               ops_equal;

  assign inst     = lat_pkt.inst;
  assign pc_plus4 = lat_pkt.pc + `ADDR_W'd4;
  assign pc_plus8 = lat_pkt.pc + `ADDR_W'd8;

  always_comb begin
    if (ctrl.lui) begin
      imm_ext = {inst.i.imm, 16'h0000};
    end else if (ctrl.sign_ext_imm) begin
      imm_ext = {{16{inst.i.imm[15]}}, inst.i.imm};
    end else begin
      imm_ext = {16'h0000, inst.i.imm};
    end
  end

  assign br_offset  = {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
  assign both_known = !rsp_1.is_rsid && !rsp_2.is_rsid;
  assign ops_equal  = (rsp_1.data == rsp_2.data);

  always_comb begin
    next_pkt                = '0;
    next_pkt.pc             = lat_pkt.pc;
    next_pkt.pred_taken     = lat_pkt.pred_taken;
    next_pkt.funct          = ctrl.funct;
    next_pkt.shamt          = ctrl.shamt;
    next_pkt.reg_write_en   = ctrl.reg_write_en;
    next_pkt.reg_write_addr = ctrl.reg_write_addr;
    next_pkt.dest_rsid      = alloc_tag;
    next_pkt.mem_read       = ctrl.mem_read;
    next_pkt.mem_write      = ctrl.mem_write;
    next_pkt.mem_sign_ext   = ctrl.mem_sign_ext;
    next_pkt.mem_sel        = ctrl.mem_sel;
    next_pkt.reserved_inst  = ctrl.reserved_inst;
    next_pkt.store          = rsp_2;

    // operand 1
    if (ctrl.lui) begin
      next_pkt.op_1 = '0;
    end else if (ctrl.branch_kind == isa_pkg::BR_JAL) begin
      next_pkt.op_1 = '{is_rsid: 1'b0, data: pc_plus8};
    end else begin
      next_pkt.op_1 = rsp_1;
    end

    // operand 2
    if (ctrl.use_imm) begin
      next_pkt.op_2 = '{is_rsid: 1'b0, data: imm_ext};
    end else begin
      next_pkt.op_2 = rsp_2;
    end

    // is_branch marks any control transfer, is_jump the unconditional ones
    case (ctrl.branch_kind)
      isa_pkg::BR_BEQ, isa_pkg::BR_BNE: begin
        next_pkt.is_branch     = 1'b1;
        next_pkt.br_determined = both_known;
        next_pkt.br_taken      = both_known &&
                                 (ops_equal == (ctrl.branch_kind == isa_pkg::BR_BEQ));
        next_pkt.br_target     = pc_plus4 + br_offset;
      end
      isa_pkg::BR_J, isa_pkg::BR_JAL: begin
        next_pkt.is_branch     = 1'b1;
        next_pkt.is_jump       = 1'b1;
        next_pkt.br_determined = 1'b1;
        next_pkt.br_taken      = 1'b1;
        next_pkt.br_target     = {pc_plus4[31:28], inst.j.index, 2'b00};
      end
      isa_pkg::BR_JR: begin
        next_pkt.is_branch     = 1'b1;
        next_pkt.is_jump       = 1'b1;
        next_pkt.br_determined = !rsp_1.is_rsid;
        next_pkt.br_taken      = !rsp_1.is_rsid;
        next_pkt.br_target     = rsp_1.data;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none

`include "id_config.svh"

package pipe_pkg;

  typedef struct packed {
    logic [`ADDR_W-1:0] pc;
    isa_pkg::inst_u     inst;
    logic               pred_taken;
  } fetch_pkt_t;

  typedef struct packed {
    logic                   en;
    logic [`REG_ADDR_W-1:0] addr;
  } rd_req_t;

  // low RSID_W bits of data carry the tag when is_rsid is set
  typedef struct packed {
    logic               is_rsid;
    logic [`DATA_W-1:0] data;
  } rd_rsp_t;

  typedef struct packed {
    isa_pkg::funct_e        funct;
    logic [`SHAMT_W-1:0]    shamt;
    rd_req_t                rd_1;
    rd_req_t                rd_2;
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_write_addr;
    logic                   use_imm;
    logic                   sign_ext_imm;
    logic                   lui;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_sign_ext;
    logic [`MEM_SEL_W-1:0]  mem_sel;
    isa_pkg::branch_kind_e  branch_kind;
    logic                   reserved_inst;
  } ctrl_t;

  typedef struct packed {
    logic [`RSID_W-1:0] tag;
    logic [`DATA_W-1:0] data;
  } wb_pkt_t;

  // operands and store data reuse the read response layout
  typedef struct packed {
    logic [`ADDR_W-1:0]     pc;
    isa_pkg::funct_e        funct;
    logic [`SHAMT_W-1:0]    shamt;
    rd_rsp_t                op_1;
    rd_rsp_t                op_2;
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_write_addr;
    logic [`RSID_W-1:0]     dest_rsid;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_sign_ext;
    logic [`MEM_SEL_W-1:0]  mem_sel;
    rd_rsp_t                store;
    logic                   is_branch;
    logic                   is_jump;
    logic                   br_taken;
    logic                   br_determined;
    logic [`ADDR_W-1:0]     br_target;
    logic                   pred_taken;
    logic                   reserved_inst;
  } dispatch_pkt_t;

endpackage

`default_nettype wire

// ==== src/reg_rename_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module reg_rename_file (
  input  wire logic                   clk,
  input  wire logic                   arst_n,
  input  wire pipe_pkg::rd_req_t      rd_1,
  input  wire pipe_pkg::rd_req_t      rd_2,
  output pipe_pkg::rd_rsp_t           rsp_1,
  output pipe_pkg::rd_rsp_t           rsp_2,
  input  wire logic                   alloc_valid,
  input  wire logic [`REG_ADDR_W-1:0] alloc_addr,
  output logic [`RSID_W-1:0]          alloc_tag,
  input  wire logic                   wb_valid,
  input  wire pipe_pkg::wb_pkt_t      wb
);

  logic [`DATA_W-1:0] values [`NUM_REGS];
  logic [`RSID_W-1:0] tags   [`NUM_REGS];
  logic [`NUM_REGS-1:0] busy;
  logic [`RSID_W-1:0] next_tag;

  // value, or pending producer tag when busy
  function automatic pipe_pkg::rd_rsp_t read_port(input pipe_pkg::rd_req_t req);
    pipe_pkg::rd_rsp_t rsp;
    rsp = '0;
    if (req.en && (req.addr != '0)) begin
      if (busy[req.addr]) begin
        rsp.is_rsid              = 1'b1;
        rsp.data[`RSID_W-1:0]    = tags[req.addr];
      end else begin
        rsp.data = values[req.addr];
      end
    end
    return rsp;
  endfunction

  always_comb begin
    rsp_1 = read_port(rd_1);
    rsp_2 = read_port(rd_2);
  end

  assign alloc_tag = next_tag;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        values[i] <= '0;
        tags[i]   <= '0;
      end
      busy     <= '0;
      next_tag <= '0;
    end else begin
      // write-back matches every register still waiting on that tag
      if (wb_valid) begin
        for (int i = 1; i < `NUM_REGS; i++) begin
          if (busy[i] && (tags[i] == wb.tag)) begin
            values[i] <= wb.data;
            busy[i]   <= 1'b0;
          end
        end
      end
      // placed after write-back so a same-cycle allocation wins
      if (alloc_valid && (alloc_addr != '0)) begin
        busy[alloc_addr] <= 1'b1;
        tags[alloc_addr] <= next_tag;
      end
      if (alloc_valid) begin
        next_tag <= next_tag + 1'b1;
      end
    end
  end

  a_no_alloc_r0: assert property (
    @(posedge clk) disable iff (!arst_n)
    alloc_valid |-> (alloc_addr != '0)
  ) else $error("tag allocated for r0");

endmodule

`default_nettype wire

// ==== tb/tb_id_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "id_config.svh"

module tb_id_top;

  logic                    clk;
  logic                    arst_n;
  logic                    fetch_valid;
  pipe_pkg::fetch_pkt_t    fetch;
  logic                    wb_valid;
  pipe_pkg::wb_pkt_t       wb;
  logic                    dispatch_valid;
  pipe_pkg::dispatch_pkt_t dispatch;

  integer seed = 16702;
  integer cyc = 0;
  integer pkt_errs = 0;
  integer time_errs = 0;
  integer other_errs = 0;

  // model of the rename table
  logic [`DATA_W-1:0]   m_val [`NUM_REGS];
  logic [`RSID_W-1:0]   m_tag [`NUM_REGS];
  logic [`NUM_REGS-1:0] m_busy;
  logic [`RSID_W-1:0]   m_next;

  // instruction sitting in the fetch latch
  logic                 lat_have;
  pipe_pkg::fetch_pkt_t lat_f;
  integer               lat_cyc;
  string                lat_name;

  pipe_pkg::dispatch_pkt_t exp_q [$];
  integer                  cyc_q [$];
  string                   name_q [$];

  id_top u_id_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .fetch_valid    (fetch_valid),
    .fetch          (fetch),
    .wb_valid       (wb_valid),
    .wb             (wb),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic pipe_pkg::rd_rsp_t model_read(input logic en, input logic [4:0] a);
    pipe_pkg::rd_rsp_t r;
    r = '0;
    if (en && a != 0) begin
      if (m_busy[a]) begin
        r.is_rsid = 1'b1;
        r.data    = {28'h0, m_tag[a]};
      end else begin
        r.data = m_val[a];
      end
    end
    return r;
  endfunction

  // expected dispatch packet from the model state before the read edge
  function automatic pipe_pkg::dispatch_pkt_t exp_dispatch(input pipe_pkg::fetch_pkt_t f);
    pipe_pkg::dispatch_pkt_t p;
    pipe_pkg::rd_rsp_t r1;
    pipe_pkg::rd_rsp_t r2;
    logic [31:0] w;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [5:0]  fun;
    logic [4:0]  sh;
    logic        en1, en2, we, use_imm, sx, lui, rsv, mr, mw, ms;
    logic [4:0]  a1, a2, wa;
    logic [3:0]  sel;
    logic [2:0]  br;
    logic [31:0] imm;
    logic [31:0] pc4;
    w = f.inst;
    op = w[31:26];
    fn = w[5:0];
    fun = 6'h21;
    sh = 0;
    {en1, en2, we, use_imm, sx, lui, rsv, mr, mw, ms} = '0;
    a1 = w[25:21];
    a2 = w[20:16];
    wa = 0;
    sel = 0;
    br = 0;
    case (op)
      6'h00: begin
        case (fn)
          6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a: begin
            fun = fn;
            {en1, en2, we} = 3'b111;
            wa = w[15:11];
          end
          6'h00, 6'h02: begin
            fun = fn;
            sh = w[10:6];
            {en2, we} = 2'b11;
            wa = w[15:11];
          end
          6'h08: begin
            en1 = 1;
            br = 5;
          end
          default: rsv = 1;
        endcase
      end
      6'h08, 6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
        {en1, use_imm, we} = 3'b111;
        wa = w[20:16];
        case (op)
          6'h08: {fun, sx} = {6'h20, 1'b1};
          6'h09: {fun, sx} = {6'h21, 1'b1};
          6'h0a: {fun, sx} = {6'h2a, 1'b1};
          6'h0c: fun = 6'h24;
          6'h0d: fun = 6'h25;
          6'h0e: fun = 6'h26;
          default: {fun, lui, en1} = {6'h25, 1'b1, 1'b0};
        endcase
      end
      6'h23, 6'h20, 6'h24: begin
        {en1, use_imm, sx, mr, we} = 5'b11111;
        ms = (op == 6'h20);
        sel = (op == 6'h23) ? 4'b1111 : 4'b0001;
        wa = w[20:16];
      end
      6'h2b, 6'h28: begin
        {en1, en2, use_imm, sx, mw} = 5'b11111;
        sel = (op == 6'h2b) ? 4'b1111 : 4'b0001;
      end
      6'h04, 6'h05: begin
        {en1, en2} = 2'b11;
        br = (op == 6'h04) ? 3'd1 : 3'd2;
      end
      6'h02: br = 3;
      6'h03: begin
        br = 4;
        we = 1;
        wa = `LINK_REG;
      end
      default: rsv = 1;
    endcase
    if (wa == 0) we = 0;
    if (rsv) begin
      {en1, en2, we, use_imm, sx, lui, mr, mw, ms} = '0;
      {fun, sh, wa, sel, br} = '0;
    end
    r1 = model_read(en1, a1);
    r2 = model_read(en2, a2);
    if (lui) imm = {w[15:0], 16'h0};
    else if (sx) imm = {{16{w[15]}}, w[15:0]};
    else imm = {16'h0, w[15:0]};
    pc4 = f.pc + 4;

    p = '0;
    p.pc = f.pc;
    p.pred_taken = f.pred_taken;
    p.funct = isa_pkg::funct_e'(fun);
    p.shamt = sh;
    p.reg_write_en = we;
    p.reg_write_addr = wa;
    p.dest_rsid = m_next;
    p.mem_read = mr;
    p.mem_write = mw;
    p.mem_sign_ext = ms;
    p.mem_sel = sel;
    p.reserved_inst = rsv;
    p.store = r2;
    if (lui) begin
      p.op_1 = '0;
    end else if (br == 4) begin
      p.op_1.is_rsid = 1'b0;
      p.op_1.data = f.pc + 8;
    end else begin
      p.op_1 = r1;
    end
    if (use_imm) begin
      p.op_2.is_rsid = 1'b0;
      p.op_2.data = imm;
    end else begin
      p.op_2 = r2;
    end
    if (br == 1 || br == 2) begin
      p.is_branch = 1;
      p.br_determined = !r1.is_rsid && !r2.is_rsid;
      p.br_taken = p.br_determined &&
                   ((br == 1) ? (r1.data == r2.data) : (r1.data != r2.data));
      p.br_target = pc4 + {{14{w[15]}}, w[15:0], 2'b00};
    end else if (br == 3 || br == 4) begin
      {p.is_branch, p.is_jump, p.br_determined, p.br_taken} = 4'b1111;
      p.br_target = {pc4[31:28], w[25:0], 2'b00};
    end else if (br == 5) begin
      {p.is_branch, p.is_jump} = 2'b11;
      p.br_determined = !r1.is_rsid;
      p.br_taken = !r1.is_rsid;
      p.br_target = r1.data;
    end
    return p;
  endfunction

  // one clock: drive inputs, queue the latched instruction, advance the model
  task automatic run_cycle(input logic do_fetch, input logic [31:0] inst, input string name,
                           input logic do_wb, input logic [3:0] wtag, input logic [31:0] wdata);
    pipe_pkg::dispatch_pkt_t p;
    @(posedge clk);
    #2;
    if (lat_have) begin
      p = exp_dispatch(lat_f);
      exp_q.push_back(p);
      cyc_q.push_back(lat_cyc + 2);
      name_q.push_back(lat_name);
    end
    if (do_wb) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        if (m_busy[i] && m_tag[i] == wtag) begin
          m_val[i] = wdata;
          m_busy[i] = 1'b0;
        end
      end
    end
    // allocation after write-back, so it wins on the same register
    if (lat_have && p.reg_write_en) begin
      m_busy[p.reg_write_addr] = 1'b1;
      m_tag[p.reg_write_addr] = p.dest_rsid;
    end
    if (lat_have && p.reg_write_en) m_next = m_next + 1'b1;
    fetch_valid = do_fetch;
    fetch.pc = {$random(seed)} & 32'hffff_fffc;
    fetch.inst = inst;
    fetch.pred_taken = $random(seed);
    wb_valid = do_wb;
    wb.tag = wtag;
    wb.data = wdata;
    lat_have = do_fetch;
    lat_f = fetch;
    lat_cyc = cyc;
    lat_name = name;
  endtask

  task automatic issue(input logic [31:0] inst, input string name);
    run_cycle(1'b1, inst, name, 1'b0, 4'h0, 32'h0);
  endtask

  function automatic logic [31:0] rand_inst();
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm;
    integer      k;
    rs = {$random(seed)} % 8;
    rt = {$random(seed)} % 8;
    rd = {$random(seed)} % 8;
    imm = $random(seed);
    k = {$random(seed)} % 10;
    case (k)
      0, 1: return enc_r(6'h20 + ({$random(seed)} % 8), rs, rt, rd, 0);
      2: return enc_r(({$random(seed)} % 2) ? 6'h02 : 6'h00, 0, rt, rd, imm[4:0]);
      3, 4: return enc_i(6'h08 + ({$random(seed)} % 8), rs, rt, imm);
      5: return enc_i(({$random(seed)} % 2) ? 6'h23 : 6'h20, rs, rt, imm);
      6: return enc_i(({$random(seed)} % 2) ? 6'h2b : 6'h28, rs, rt, imm);
      7: return enc_i(6'h04 + ({$random(seed)} % 2), rs, rt, imm);
      8: return ({$random(seed)} % 2) ? {6'h03, 10'h0, imm} : enc_r(6'h08, rs, 0, 0, 0);
      default: return ({$random(seed)} % 2) ? {6'h3f, 26'h0} : {6'h02, 10'h0, imm};
    endcase
  endfunction

  // compare at the falling edge where outputs are stable
  always @(negedge clk) begin
    if (arst_n) begin
      if (exp_q.size() > 0 && cyc_q[0] < cyc) begin
        $display("dispatch missing for %s, expected in cycle %0d", name_q[0], cyc_q[0]);
        time_errs++;
        void'(exp_q.pop_front());
        void'(cyc_q.pop_front());
        void'(name_q.pop_front());
      end
      if (dispatch_valid) begin
        if (exp_q.size() == 0 || cyc_q[0] != cyc) begin
          $display("dispatch_valid high in cycle %0d with no fetch due", cyc);
          time_errs++;
        end else begin
          assert (dispatch == exp_q[0])
          else begin
            $display("Fail %s: expected %h actual %h", name_q[0], exp_q[0], dispatch);
            pkt_errs++;
          end
          void'(exp_q.pop_front());
          void'(cyc_q.pop_front());
          void'(name_q.pop_front());
        end
      end
    end
  end

  initial begin
    integer      wait_cnt;
    logic [3:0]  t;
    arst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch = '0;
    wb_valid = 1'b0;
    wb = '0;
    lat_have = 1'b0;
    lat_f = '0;
    lat_cyc = 0;
    lat_name = "";
    for (int i = 0; i < `NUM_REGS; i++) begin
      m_val[i] = '0;
      m_tag[i] = '0;
    end
    m_busy = '0;
    m_next = '0;
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;

    // quiet after reset
    repeat (4) run_cycle(1'b0, 32'h0, "idle", 1'b0, 4'h0, 32'h0);
    issue(enc_r(6'h21, 1, 2, 3, 0), "read_zero");
    issue(enc_i(6'h08, 0, 4, 16'h8001), "addi");
    issue(enc_i(6'h0c, 0, 6, 16'h8001), "andi");
    issue(enc_i(6'h0f, 0, 7, 16'h1234), "lui");
    issue(enc_i(6'h23, 0, 8, 16'hfff0), "lw");
    issue(enc_i(6'h20, 0, 9, 16'h0003), "lb");
    issue(enc_i(6'h24, 0, 10, 16'h0002), "lbu");
    issue(enc_i(6'h2b, 4, 8, 16'h0004), "sw");
    issue(enc_i(6'h28, 0, 9, 16'h0001), "sb");
    issue(enc_r(6'h00, 0, 4, 11, 5'd3), "sll");
    issue({6'h3f, 26'h3ff_ffff}, "bad_opcode");
    issue(enc_r(6'h3f, 1, 2, 3, 0), "bad_funct");

    // 18 writes to r5 wrap the tag counter
    repeat (18) issue(enc_i(6'h09, 0, 5, 16'h0001), "rename");
    issue(enc_r(6'h20, 5, 5, 12, 0), "rename_read");
    run_cycle(1'b0, 32'h0, "idle", 1'b0, 4'h0, 32'h0);
    t = m_tag[5];
    run_cycle(1'b0, 32'h0, "idle", 1'b1, t, 32'h1234_5678);
    issue(enc_r(6'h21, 5, 0, 13, 0), "wb_read");
    t = m_tag[12];
    issue(enc_i(6'h09, 0, 12, 16'h0007), "wb_alloc");
    run_cycle(1'b1, enc_r(6'h21, 12, 0, 14, 0), "wb_alloc_read", 1'b1, t, 32'hdead_beef);

    issue(enc_i(6'h04, 0, 0, 16'hfffe), "beq_known");
    issue(enc_i(6'h05, 5, 0, 16'h0010), "bne_known");
    issue(enc_i(6'h04, 4, 0, 16'h0010), "beq_rsid");
    issue({6'h02, 26'h123_4567}, "j");
    issue({6'h03, 26'h0ab_cdef}, "jal");
    issue(enc_r(6'h08, 5, 0, 0, 0), "jr_known");
    issue(enc_r(6'h08, 31, 0, 0, 0), "jr_rsid");

    for (int n = 0; n < 300; n++) begin
      run_cycle(1'b1, rand_inst(), "random", ({$random(seed)} % 3) == 0,
                $random(seed), $random(seed));
    end
    repeat (2) run_cycle(1'b0, 32'h0, "idle", 1'b0, 4'h0, 32'h0);

    wait_cnt = 0;
    while (exp_q.size() > 0 && wait_cnt < 20) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout with %0d dispatches still outstanding", exp_q.size());
      other_errs++;
    end
    @(posedge clk);
    $display("errors: packet %0d, timing %0d, other %0d", pkt_errs, time_errs, other_errs);
    if (pkt_errs + time_errs + other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
